/* rtl/csr_pkg.sv */
package csr_pkg;

  // Machine-mode CSR numbers
  typedef logic [11:0] csr_addr_t;

  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MIE       = 12'h304;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MIP       = 12'h344;
  localparam csr_addr_t CSR_MCYCLE    = 12'hB00;
  localparam csr_addr_t CSR_MINSTRET  = 12'hB02;
  localparam csr_addr_t CSR_MCYCLEH   = 12'hB80;
  localparam csr_addr_t CSR_MINSTRETH = 12'hB82;
  localparam csr_addr_t CSR_MVENDORID = 12'hF11;
  localparam csr_addr_t CSR_MARCHID   = 12'hF12;
  localparam csr_addr_t CSR_MIMPID    = 12'hF13;
  localparam csr_addr_t CSR_MHARTID   = 12'hF14;

  localparam logic [31:0] MTVEC_BASE = 32'h0001_0000;  // Direct mode only

  localparam int MEIE_BIT = 11;
  localparam int MEIP_BIT = 11;

  // MIE, MPIE and MPP are the only writable mstatus bits
  localparam logic [31:0] MSTATUS_WMASK = 32'h0000_1888;
  localparam logic [1:0]  MPP_M         = 2'b11;

  typedef enum logic [2:0] {
    OP_RW   = 3'd0,
    OP_RS   = 3'd1,
    OP_RC   = 3'd2,
    OP_MRET = 3'd3,
    OP_WFI  = 3'd4
  } csr_op_e;

  // Command as held by the pipeline while req_i is high
  typedef struct packed {
    csr_op_e     op;
    csr_addr_t   addr;
    logic [31:0] wdata;
  } csr_cmd_t;

  // One-cycle access from the command port to the register file
  typedef struct packed {
    logic        valid;
    csr_op_e     op;
    csr_addr_t   addr;
    logic [31:0] operand;
  } csr_access_t;

  typedef struct packed {
    logic [18:0] zero_hi;   // 31:13
    logic [1:0]  mpp;       // 12:11
    logic [2:0]  zero_mid;  // 10:8
    logic        mpie;      // 7
    logic [2:0]  zero_lo;   // 6:4
    logic        mie;       // 3
    logic [2:0]  zero_bot;  // 2:0
  } mstatus_fields_t;

  typedef union packed {
    logic [31:0]     raw;
    mstatus_fields_t f;
  } csr_word_u;

  typedef struct packed {
    logic        valid;
    logic [31:0] target;
  } redirect_t;

endpackage

/* rtl/csr_cmd_port.sv */
`timescale 1ns/1ns

module csr_cmd_port (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  req_i,
  input  csr_pkg::csr_cmd_t     cmd_i,
  output logic                  ack_o,
  output logic [31:0]           rdata_o,
  output csr_pkg::csr_access_t  access_o,
  input  logic [31:0]           rd_data_i,
  input  logic                  wake_i,
  output logic                  busy_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_WAIT_WAKE,
    ST_ACKED
  } state_e;

  state_e state_q;
  state_e state_d;

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (req_i) begin
          state_d = (cmd_i.op == csr_pkg::OP_WFI) ? ST_WAIT_WAKE : ST_ACCESS;
        end
      end
      ST_WAIT_WAKE: begin
        if (wake_i) begin
          state_d = ST_ACCESS;  // Retire the wfi once woken
        end
      end
      ST_ACCESS: state_d = ST_ACKED;
      ST_ACKED: begin
        if (!req_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Read data captured together with the register update
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rdata_o <= '0;
    end else if (state_q == ST_ACCESS) begin
      rdata_o <= (cmd_i.op == csr_pkg::OP_WFI) ? 32'h0 : rd_data_i;
    end
  end

  // cmd_i is stable while req_i is high, so it feeds the access directly
  always_comb begin
    access_o.valid   = (state_q == ST_ACCESS);
    access_o.op      = cmd_i.op;
    access_o.addr    = cmd_i.addr;
    access_o.operand = cmd_i.wdata;
  end

  assign ack_o  = (state_q == ST_ACKED);
  assign busy_o = req_i || (state_q != ST_IDLE);  // Keeps traps out of a command

endmodule

/* rtl/csr_regfile.sv */
`timescale 1ns/1ns

module csr_regfile (
  input  logic                  clk,
  input  logic                  rstn,
  input  csr_pkg::csr_access_t  access_i,
  output logic [31:0]           rd_data_o,
  input  logic [31:0]           pc_i,
  input  logic                  meip_i,
  input  logic                  take_i,
  output logic                  irq_ready_o,
  output csr_pkg::redirect_t    ret_o
);

  csr_pkg::csr_word_u mstatus;
  logic               meie;
  logic [31:0]        mepc;
  logic [63:0]        mcycle;
  logic [63:0]        minstret;

  logic [31:0] mie_word;
  logic [31:0] mip_word;
  logic [31:0] csr_val;   // Current value at access_i.addr
  logic [31:0] wdata;     // Value after the read-modify-write
  logic        wr_en;
  logic        ret_en;

  always_comb begin
    mie_word           = '0;
    mie_word[csr_pkg::MEIE_BIT] = meie;
    mip_word           = '0;
    mip_word[csr_pkg::MEIP_BIT] = meip_i;
  end

  // Read decode
  always_comb begin
    unique case (access_i.addr)
      csr_pkg::CSR_MSTATUS:   csr_val = mstatus.raw;
      csr_pkg::CSR_MIE:       csr_val = mie_word;
      csr_pkg::CSR_MTVEC:     csr_val = csr_pkg::MTVEC_BASE;
      csr_pkg::CSR_MEPC:      csr_val = mepc;
      csr_pkg::CSR_MIP:       csr_val = mip_word;
      csr_pkg::CSR_MCYCLE:    csr_val = mcycle[31:0];
      csr_pkg::CSR_MCYCLEH:   csr_val = mcycle[63:32];
      csr_pkg::CSR_MINSTRET:  csr_val = minstret[31:0];
      csr_pkg::CSR_MINSTRETH: csr_val = minstret[63:32];
      csr_pkg::CSR_MVENDORID,
      csr_pkg::CSR_MARCHID,
      csr_pkg::CSR_MIMPID,
      csr_pkg::CSR_MHARTID:   csr_val = 32'h0;
      default:                csr_val = 32'h0;
    endcase
  end

  // mret returns the saved pc instead of a CSR
  assign rd_data_o = (access_i.op == csr_pkg::OP_MRET) ? mepc : csr_val;

  always_comb begin
    unique case (access_i.op)
      csr_pkg::OP_RS: wdata = csr_val | access_i.operand;
      csr_pkg::OP_RC: wdata = csr_val & ~access_i.operand;
      default:        wdata = access_i.operand;
    endcase
  end

  assign wr_en = access_i.valid && (access_i.op == csr_pkg::OP_RW ||
                                    access_i.op == csr_pkg::OP_RS ||
                                    access_i.op == csr_pkg::OP_RC);
  assign ret_en = access_i.valid && (access_i.op == csr_pkg::OP_MRET);

  // mstatus: trap entry, then mret, then software writes
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mstatus.raw <= '0;
    end else if (take_i) begin
      mstatus.f.mpie <= mstatus.f.mie;
      mstatus.f.mie  <= 1'b0;
      mstatus.f.mpp  <= csr_pkg::MPP_M;
    end else if (ret_en) begin
      mstatus.f.mie  <= mstatus.f.mpie;
      mstatus.f.mpie <= 1'b1;
      mstatus.f.mpp  <= csr_pkg::MPP_M;
    end else if (wr_en && access_i.addr == csr_pkg::CSR_MSTATUS) begin
      mstatus.raw <= wdata & csr_pkg::MSTATUS_WMASK;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      meie <= 1'b0;
    end else if (wr_en && access_i.addr == csr_pkg::CSR_MIE) begin
      meie <= wdata[csr_pkg::MEIE_BIT];  // Only MEIE is implemented
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mepc <= '0;
    end else if (take_i) begin
      mepc <= pc_i;
    end else if (wr_en && access_i.addr == csr_pkg::CSR_MEPC) begin
      mepc <= {wdata[31:2], 2'b00};
    end
  end

  // Counters, read-only from software
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mcycle   <= '0;
      minstret <= '0;
    end else begin
      mcycle <= mcycle + 64'd1;
      if (access_i.valid) begin
        minstret <= minstret + 64'd1;  // One per retired command
      end
    end
  end

  assign irq_ready_o = mstatus.f.mie && meie && meip_i;

  assign ret_o.valid  = ret_en;
  assign ret_o.target = mepc;

endmodule

/* rtl/csr_trap_ctrl.sv */
`timescale 1ns/1ns

module csr_trap_ctrl (
  input  logic                clk,
  input  logic                rstn,
  input  logic                irq_i,
  input  logic                irq_ready_i,
  input  logic                busy_i,
  input  csr_pkg::redirect_t  ret_i,
  output logic                meip_o,
  output logic                take_o,
  output logic                wake_o,
  output csr_pkg::redirect_t  redirect_o
);

  logic irq_meta;
  logic irq_sync;

  // Two-flop synchroniser on the external interrupt
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      irq_meta <= 1'b0;
      irq_sync <= 1'b0;
    end else begin
      irq_meta <= irq_i;
      irq_sync <= irq_meta;
    end
  end

  assign meip_o = irq_sync;

  // wfi wakes on any pending interrupt, enabled globally or not
  assign wake_o = irq_sync;

  // Traps wait for the command port to go idle
  assign take_o = irq_ready_i && !busy_i;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      redirect_o <= '0;
    end else if (take_o) begin
      redirect_o.valid  <= 1'b1;
      redirect_o.target <= csr_pkg::MTVEC_BASE;
    end else if (ret_i.valid) begin
      redirect_o <= ret_i;  // Back to mepc
    end else begin
      redirect_o.valid <= 1'b0;
    end
  end

endmodule

/* rtl/csr_unit.sv */
`timescale 1ns/1ns

module csr_unit (
  input  logic                clk,
  input  logic                rstn,
  input  logic                req_i,
  input  csr_pkg::csr_cmd_t   cmd_i,
  output logic                ack_o,
  output logic [31:0]         rdata_o,
  input  logic                irq_i,
  input  logic [31:0]         pc_i,
  output csr_pkg::redirect_t  redirect_o
);

  csr_pkg::csr_access_t access;
  logic [31:0]          rd_data;
  logic                 busy;
  logic                 wake;
  logic                 meip;
  logic                 take;
  logic                 irq_ready;
  csr_pkg::redirect_t   ret;

  csr_cmd_port i_cmd_port (
    .clk       (clk),
    .rstn      (rstn),
    .req_i     (req_i),
    .cmd_i     (cmd_i),
    .ack_o     (ack_o),
    .rdata_o   (rdata_o),
    .access_o  (access),
    .rd_data_i (rd_data),
    .wake_i    (wake),
    .busy_o    (busy)
  );

  csr_regfile i_regfile (
    .clk         (clk),
    .rstn        (rstn),
    .access_i    (access),
    .rd_data_o   (rd_data),
    .pc_i        (pc_i),
    .meip_i      (meip),
    .take_i      (take),
    .irq_ready_o (irq_ready),
    .ret_o       (ret)
  );

  csr_trap_ctrl i_trap_ctrl (
    .clk         (clk),
    .rstn        (rstn),
    .irq_i       (irq_i),
    .irq_ready_i (irq_ready),
    .busy_i      (busy),
    .ret_i       (ret),
    .meip_o      (meip),
    .take_o      (take),
    .wake_o      (wake),
    .redirect_o  (redirect_o)
  );

endmodule

/* test/csr_unit_chk.sv */
`timescale 1ns/1ns

module csr_unit_chk (
  input logic               clk,
  input logic               rstn,
  input logic               req_i,
  input logic               ack_i,
  input logic [31:0]        rdata_i,
  input csr_pkg::redirect_t redirect_i
);

  int fail_count = 0;

  // ack_o is registered, so the request it answers is the one seen an edge earlier
  ack_needs_req: assert property (@(posedge clk) disable iff (!rstn)
      $rose(ack_i) |-> $past(req_i))
    else begin
      fail_count++;
      $error("ack_o rose while req_i was low");
    end

  // Four-phase return to zero
  ack_falls_after_req: assert property (@(posedge clk) disable iff (!rstn)
      $fell(ack_i) |-> !$past(req_i))
    else begin
      fail_count++;
      $error("ack_o fell while req_i was still high");
    end

  redirect_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
      redirect_i.valid |=> !redirect_i.valid)
    else begin
      fail_count++;
      $error("redirect_o.valid held longer than one cycle");
    end

  rdata_stable: assert property (@(posedge clk) disable iff (!rstn)
      ack_i && $past(ack_i) |-> $stable(rdata_i))
    else begin
      fail_count++;
      $error("rdata_o changed while ack_o was high");
    end

endmodule

bind csr_unit csr_unit_chk i_chk (
  .clk        (clk),
  .rstn       (rstn),
  .req_i      (req_i),
  .ack_i      (ack_o),
  .rdata_i    (rdata_o),
  .redirect_i (redirect_o)
);

/* test/tb_csr_unit.sv */
`timescale 1ns/1ns

module tb_csr_unit;

  logic               clk = 1'b0;
  logic               rstn;
  logic               req_i;
  csr_pkg::csr_cmd_t  cmd_i;
  logic               ack_o;
  logic [31:0]        rdata_o;
  logic               irq_i;
  logic [31:0]        pc_i;
  csr_pkg::redirect_t redirect_o;

  int          errors = 0;
  int          cycles = 0;
  int          cycle_limit = 0;
  int          n_done = 0;          // Commands completed since reset
  logic [31:0] trap_pc = '0;        // pc_i when the interrupt was raised
  logic [31:0] last_cycle = '0;
  logic [31:0] redir_q[$];
  string       lines[$];

  csr_unit i_dut (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout: the DUT made no progress within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  // Redirect pulses, sampled away from the active edge
  always @(negedge clk) begin
    if (redirect_o.valid) begin
      redir_q.push_back(redirect_o.target);
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [31:0] mstatus_word(input logic mie, input logic mpie,
                                               input logic [1:0] mpp);
    csr_pkg::csr_word_u w;
    w.raw    = '0;
    w.f.mie  = mie;
    w.f.mpie = mpie;
    w.f.mpp  = mpp;
    return w.raw;
  endfunction

  // Token from the tests file to a value
  function automatic logic [31:0] expect_value(input string tok);
    if (tok == "pc") begin
      return trap_pc;
    end
    if (tok == "ninst") begin
      return 32'(n_done);  // minstret before this command retires
    end
    if (tok.len() == 6 && tok.substr(0, 2) == "ms_") begin
      return mstatus_word(tok[3] == "1", tok[4] == "1", 2'(tok[5] - 8'h30));
    end
    return 32'(tok.atohex());
  endfunction

  // One full four-phase transfer
  task automatic do_cmd(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                        input logic [31:0] wdata, input bit wake, output logic [31:0] rdata);
    int gap;
    int hold;
    @(negedge clk);
    cmd_i.op    = op;
    cmd_i.addr  = addr;
    cmd_i.wdata = wdata;
    req_i       = 1'b1;
    if (wake) begin
      gap = 3 + int'($urandom % 8);
      repeat (gap) begin
        @(negedge clk);
        check("ack_o", {31'b0, ack_o}, 32'h0);  // wfi still sleeping
      end
      irq_i = 1'b1;
    end
    while (!ack_o) @(negedge clk);
    rdata = rdata_o;
    hold  = int'($urandom % 4);
    repeat (hold) @(negedge clk);
    req_i = 1'b0;
    while (ack_o) @(negedge clk);
    n_done++;
  endtask

  task automatic wait_redirect(input string tok);
    logic [31:0] target;
    while (redir_q.size() == 0) @(negedge clk);
    target = redir_q.pop_front();
    check("redirect_o.target", target, expect_value(tok));
  endtask

  task automatic run_test(input int id, input string op_s, input logic [11:0] addr,
                          input logic [31:0] wdata, input string irq_s, input string exp_s,
                          input string red_s);
    csr_pkg::csr_op_e op;
    logic [31:0]      rdata;
    logic [31:0]      exp;
    int               err_before;
    err_before = errors;
    case (op_s)
      "rw":   op = csr_pkg::OP_RW;
      "rs":   op = csr_pkg::OP_RS;
      "rc":   op = csr_pkg::OP_RC;
      "mret": op = csr_pkg::OP_MRET;
      "wfi":  op = csr_pkg::OP_WFI;
      default: begin
        $display("Test %0d names an unknown command %s", id, op_s);
        errors++;
        op = csr_pkg::OP_RS;
      end
    endcase
    if (irq_s == "raise") begin
      @(negedge clk);
      pc_i    = $urandom & 32'hFFFF_FFFC;
      trap_pc = pc_i;
      irq_i   = 1'b1;
    end else if (irq_s == "drop") begin
      @(negedge clk);
      irq_i = 1'b0;
      repeat (3) @(negedge clk);  // Through the synchroniser
    end
    if (red_s != "none" && op != csr_pkg::OP_MRET) begin
      wait_redirect(red_s);  // Trap comes before the command
    end
    exp = expect_value(exp_s);
    do_cmd(op, addr, wdata, irq_s == "wake", rdata);
    if (exp_s == "up") begin
      check("mcycle_increased", {31'b0, rdata > last_cycle}, 32'h1);
      last_cycle = rdata;
    end else begin
      check("rdata_o", rdata, exp);
    end
    if (red_s != "none" && op == csr_pkg::OP_MRET) begin
      wait_redirect(red_s);
    end
    if (red_s == "none" && redir_q.size() != 0) begin
      $display("Test %0d: redirect to %h was not expected", id, redir_q[0]);
      errors++;
      redir_q.delete();
    end
    $display("Test %0d %s %h: %s", id, op_s, addr, (errors == err_before) ? "ok" : "mismatch");
  endtask

  initial begin
    int          fd;
    int          id;
    int          n_asrt;
    string       line;
    string       op_s;
    string       irq_s;
    string       exp_s;
    string       red_s;
    logic [11:0] addr;
    logic [31:0] wdata;
    rstn  = 1'b0;
    req_i = 1'b0;
    cmd_i = '0;
    irq_i = 1'b0;
    pc_i  = '0;
    void'($urandom(55285));
    fd = $fopen("test/csr_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open test/csr_tests.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
    cycle_limit = lines.size() * 64;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    foreach (lines[i]) begin
      if ($sscanf(lines[i], "%d %s %h %h %s %s %s",
                  id, op_s, addr, wdata, irq_s, exp_s, red_s) != 7) begin
        $display("Line %0d of the tests file cannot be parsed", i + 1);
        errors++;
      end else begin
        run_test(id, op_s, addr, wdata, irq_s, exp_s, red_s);
      end
    end
    n_asrt = i_dut.i_chk.fail_count;
    $display("%0d tests, %0d check errors, %0d assertion failures",
             lines.size(), errors, n_asrt);
    if (errors == 0 && n_asrt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* test/csr_tests.txt */
# id op addr wdata irq(none|raise|drop|wake) rdata redirect(none|hex|pc)
# rdata: hex, pc = trapped pc, ninst = commands so far, up = above last, ms_<mie><mpie><mpp>
1 rs 300 00000000 none 00000000 none
2 rs 304 00000000 none 00000000 none
3 rs 305 00000000 none 00010000 none
4 rs 341 00000000 none 00000000 none
5 rs 344 00000000 none 00000000 none
6 rs f11 00000000 none 00000000 none
7 rs f14 00000000 none 00000000 none
8 rs 7c0 00000000 none 00000000 none
9 rs b02 00000000 none ninst none
10 rw 300 ffffffff none 00000000 none
11 rc 300 00000008 none 00001888 none
12 rs 300 00000000 none ms_013 none
13 rw 304 ffffffff none 00000000 none
14 rs 304 00000000 none 00000800 none
15 rw 341 12345677 none 00000000 none
16 rc 341 ffff0000 none 12345674 none
17 rs 341 00000000 none 00005674 none
18 rw 305 deadbeef none 00010000 none
19 rs 305 00000000 none 00010000 none
20 rw 344 ffffffff none 00000000 none
21 rs 344 00000000 none 00000000 none
22 rw f12 ffffffff none 00000000 none
23 rs b00 00000000 none up none
24 rs b02 00000000 none ninst none
25 rs b00 00000000 none up none
26 rs 300 00000008 none ms_013 none
27 rs 341 00000000 raise pc 00010000
28 rs 300 00000000 none ms_013 none
29 mret 000 00000000 drop pc pc
30 rc 300 00000008 none ms_113 none
31 wfi 000 00000000 wake 00000000 none
32 rs 344 00000000 none 00000800 none

/* flist.f */
rtl/csr_pkg.sv
rtl/csr_cmd_port.sv
rtl/csr_regfile.sv
rtl/csr_trap_ctrl.sv
rtl/csr_unit.sv
test/csr_unit_chk.sv
test/tb_csr_unit.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module tb_csr_unit -f flist.f || exit 1
./obj_dir/Vtb_csr_unit +verilator+error+limit+1000 | tee /dev/stderr \
  | grep "Test completed successfully" > /dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
